//--- files.f
div_pkg.sv
div_decode.sv
div_iter_core.sv
div_result.sv
div_unit.sv
div_checker.sv
div_assertions.sv
tb_div_unit.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_div_unit
FILELIST  := files.f
SIMFLAGS  := +verilator+error+limit+100
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_div_unit.sv
// seeded random testbench for div_unit; result back-pressure never exceeds 8 cycles in a row
`timescale 1ns/100ps

module tb_div_unit;

  localparam int NUM_REQ   = 400;
  localparam int MAX_STALL = 8;
  localparam int TIMEOUT   = NUM_REQ * (66 + MAX_STALL) + 100;  // in clock cycles

  logic              clk;
  logic              rst_n;
  logic              req_valid_i;
  logic              req_ready_o;
  div_pkg::div_req_t req_i;
  logic              res_valid_o;
  logic              res_ready_i;
  div_pkg::xlen_t    res_data_o;

  integer            seed;
  int                stall;
  int                n;
  int                cycles = 0;
  int                timeout_errs = 0;
  int                mismatch_errs;
  int                protocol_errs;
  int                resp_count;
  div_pkg::div_req_t req;

  div_unit DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_data_o  (res_data_o)
  );

  div_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .req_ready_i     (req_ready_o),
    .req_i           (req_i),
    .res_valid_i     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_data_i      (res_data_o),
    .mismatch_errs_o (mismatch_errs),
    .protocol_errs_o (protocol_errs),
    .resp_count_o    (resp_count)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ====================
  // stimulus helpers
  // ====================
  task automatic next_cycle();
    @(negedge clk);
    if (stall >= MAX_STALL || ($random(seed) & 3) != 0) begin
      res_ready_i = 1'b1;
      stall       = 0;
    end else begin
      res_ready_i = 1'b0;  // stall the result this cycle
      stall++;
    end
  endtask

  task automatic pick_operand(output div_pkg::xlen_t v);
    logic [31:0] hi;
    logic [31:0] lo;
    int          sel;
    hi  = $random(seed);
    lo  = $random(seed);
    sel = $random(seed) & 15;
    case (sel)
      0:       v = '0;
      1:       v = '1;
      2:       v = 64'h8000_0000_0000_0000;
      3:       v = {hi, 32'h8000_0000};  // word min, junk above
      4:       v = {hi, 32'hffff_ffff};  // word -1
      5:       v = {hi, 32'h0};          // word zero
      6:       v = {56'b0, lo[7:0]};
      7:       v = -{56'b0, lo[7:0]};
      default: v = {hi, lo};
    endcase
  endtask

  task automatic build_request(output div_pkg::div_req_t r);
    logic [31:0] junk;
    logic        word_op;
    r.op = div_pkg::div_op_e'(3'($random(seed)));
    pick_operand(r.dividend);
    pick_operand(r.divisor);
    junk    = $random(seed);
    word_op = r.op inside {div_pkg::OP_DIVW, div_pkg::OP_DIVUW,
                           div_pkg::OP_REMW, div_pkg::OP_REMUW};
    if (($random(seed) & 7) == 0) begin  // most negative / -1 pair
      r.dividend = word_op ? {junk, 32'h8000_0000} : 64'h8000_0000_0000_0000;
      r.divisor  = word_op ? {~junk, 32'hffff_ffff} : '1;
    end
  endtask

  function automatic int total_errors();
    return mismatch_errs + protocol_errs + timeout_errs + DUT.u_assertions.assert_errs;
  endfunction

  task automatic print_counts();
    $display("errors: mismatch %0d, protocol %0d, assertion %0d, timeout %0d, responses %0d/%0d",
             mismatch_errs, protocol_errs, DUT.u_assertions.assert_errs, timeout_errs,
             resp_count, NUM_REQ);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    seed        = 91;
    stall       = 0;
    rst_n       = 1'b1;  // in reset
    req_valid_i = 1'b0;
    req_i       = '0;
    res_ready_i = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b0;
    for (n = 0; n < NUM_REQ; n++) begin
      repeat ($random(seed) & 3) next_cycle();
      build_request(req);
      req_valid_i = 1'b1;
      req_i       = req;
      while (!req_ready_o) next_cycle();  // valid held until the unit is idle
      next_cycle();
      req_valid_i = 1'b0;
    end
    while (resp_count < NUM_REQ) next_cycle();
    print_counts();
    if (total_errors() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      timeout_errs++;
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      print_counts();
      $display("TB FAILED");
      $finish;
    end
  end

endmodule

//--- div_assertions.sv
// handshake and latency properties of div_unit; latencies count from the accepting edge
`timescale 1ns/100ps

module div_assertions (
  input logic           clk,
  input logic           rst_n,
  input logic           req_valid_i,
  input logic           req_ready_i,
  input logic           res_valid_i,
  input logic           res_ready_i,
  input div_pkg::xlen_t res_data_i,
  input logic           job_special_i,
  input logic           job_word_i
);

  int   assert_errs = 0;
  logic accept;

  assign accept = req_valid_i & req_ready_i;

  // ====================
  // properties
  // ====================
  hold_a: assert property (@(posedge clk) disable iff (rst_n)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_data_i))
    else begin assert_errs++; $error("held result dropped or changed"); end

  excl_a: assert property (@(posedge clk) disable iff (rst_n)
    !(req_ready_i && res_valid_i))
    else begin assert_errs++; $error("req_ready_o and res_valid_o high together"); end

  special_a: assert property (@(posedge clk) disable iff (rst_n)
    accept && job_special_i |=> res_valid_i)
    else begin assert_errs++; $error("special result not ready one cycle after accept"); end

  // 64 or 32 iteration edges after the accepting edge
  rise_a: assert property (@(posedge clk) disable iff (rst_n)
    $rose(res_valid_i) |-> $past(accept && job_special_i) ||
      $past(accept && !job_special_i && job_word_i, 33) ||
      $past(accept && !job_special_i && !job_word_i, 65))
    else begin assert_errs++; $error("result valid at an unexpected latency"); end

endmodule

bind div_unit div_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .req_valid_i   (req_valid_i),
  .req_ready_i   (req_ready_o),
  .res_valid_i   (res_valid_o),
  .res_ready_i   (res_ready_i),
  .res_data_i    (res_data_o),
  .job_special_i (job.special),
  .job_word_i    (job.is_word)
);

//--- div_checker.sv
// scoreboard for div_unit; expected results follow the rv64m definition, in handshake order
`timescale 1ns/100ps

module div_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  logic              req_ready_i,
  input  div_pkg::div_req_t req_i,
  input  logic              res_valid_i,
  input  logic              res_ready_i,
  input  div_pkg::xlen_t    res_data_i,
  output int                mismatch_errs_o,
  output int                protocol_errs_o,
  output int                resp_count_o
);

  div_pkg::xlen_t expect_q[$];
  div_pkg::xlen_t exp_val;
  logic           first_cycle;  // first edge out of reset

  function automatic div_pkg::xlen_t sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // ====================
  // reference model
  // ====================
  function automatic div_pkg::xlen_t ref_result(input div_pkg::div_req_t r);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic               ovf;
    logic               ovf_w;
    sa    = r.dividend;
    sb    = r.divisor;
    wa    = r.dividend[31:0];
    wb    = r.divisor[31:0];
    ovf   = (r.dividend == 64'h8000_0000_0000_0000) && (sb == -1);
    ovf_w = (r.dividend[31:0] == 32'h8000_0000) && (wb == -1);
    case (r.op)
      div_pkg::OP_DIV:   return (sb == 0) ? '1 : (ovf ? r.dividend : $unsigned(sa / sb));
      div_pkg::OP_REM:   return (sb == 0) ? r.dividend : (ovf ? '0 : $unsigned(sa % sb));
      div_pkg::OP_DIVU:  return (sb == 0) ? '1 : r.dividend / r.divisor;
      div_pkg::OP_REMU:  return (sb == 0) ? r.dividend : r.dividend % r.divisor;
      div_pkg::OP_DIVW:  return (wb == 0) ? '1 : (ovf_w ? sext32(wa) : sext32(wa / wb));
      div_pkg::OP_REMW:  return (wb == 0) ? sext32(wa) : (ovf_w ? '0 : sext32(wa % wb));
      div_pkg::OP_DIVUW: return (wb == 0) ? '1 : sext32(r.dividend[31:0] / r.divisor[31:0]);
      default:           return (wb == 0) ? sext32(wa)
                                          : sext32(r.dividend[31:0] % r.divisor[31:0]);
    endcase
  endfunction

  // ====================
  // compare
  // ====================
  always @(posedge clk) begin
    if (rst_n) begin
      first_cycle     <= 1'b1;
      mismatch_errs_o = 0;
      protocol_errs_o = 0;
      resp_count_o    = 0;
    end else begin
      if (first_cycle) begin  // idle state straight after reset
        if (req_ready_i !== 1'b1) begin
          $display("FAIL req_ready_o expected %h got %h", 1'b1, req_ready_i);
          mismatch_errs_o++;
        end
        if (res_valid_i !== 1'b0) begin
          $display("FAIL res_valid_o expected %h got %h", 1'b0, res_valid_i);
          mismatch_errs_o++;
        end
        first_cycle <= 1'b0;
      end
      if (req_valid_i && req_ready_i) begin
        if (expect_q.size() != 0) begin  // one division in flight
          $display("a request was accepted while a result was still outstanding");
          protocol_errs_o++;
        end
        expect_q.push_back(ref_result(req_i));
      end
      if (res_valid_i && res_ready_i) begin
        if (expect_q.size() == 0) begin
          $display("a result was taken while no request was outstanding");
          protocol_errs_o++;
        end else begin
          exp_val = expect_q.pop_front();
          if (res_data_i !== exp_val) begin
            $display("FAIL res_data_o expected %h got %h", exp_val, res_data_i);
            mismatch_errs_o++;
          end
        end
        resp_count_o++;
      end
    end
  end

endmodule

//--- div_unit.sv
// rv64m divide unit top; one request in flight, result held until taken, no cancel input
`timescale 1ns/100ps

module div_unit (
  input  logic              clk,
  input  logic              rst_n,
  // request side
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  div_pkg::div_req_t req_i,
  // response side
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output div_pkg::xlen_t    res_data_o
);

  div_pkg::div_job_t job;  // decode -> execute
  div_pkg::div_raw_t raw;  // execute -> result

  // ====================
  // stages
  // ====================
  div_decode u_decode (
    .req_i (req_i),
    .job_o (job)
  );

  div_iter_core u_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .job_i       (job),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .raw_o       (raw)
  );

  div_result u_result (
    .raw_i      (raw),
    .res_data_o (res_data_o)
  );

endmodule

//--- div_result.sv
// result formatting, purely combinational; res_data_o is meaningful only while res_valid_o is high
`timescale 1ns/100ps

module div_result (
  input  div_pkg::div_raw_t raw_i,
  output div_pkg::xlen_t    res_data_o
);

  div_pkg::xlen_t chosen;
  div_pkg::xlen_t signed_val;
  div_pkg::half_t word_val;
  logic           negate;

  // ====================
  // select and sign fix
  // ====================
  assign chosen = raw_i.is_rem ? raw_i.remainder : raw_i.quotient;
  assign negate = raw_i.is_rem ? raw_i.rem_neg : raw_i.quot_neg;

  assign signed_val = negate ? -chosen : chosen;  // two's complement negate
  assign word_val   = signed_val[31:0];

  // ====================
  // final value
  // ====================
  // special results come from decode already sign-extended
  always_comb begin
    if (raw_i.special) begin
      res_data_o = raw_i.special_val;
    end else if (raw_i.is_word) begin
      res_data_o = {{32{word_val[31]}}, word_val};  // *w ops sext bit 31
    end else begin
      res_data_o = signed_val;
    end
  end

endmodule

//--- div_iter_core.sv
// restoring divider, one quotient bit per cycle; a single job in flight, no flush
`timescale 1ns/100ps

module div_iter_core (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  div_pkg::div_job_t job_i,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output div_pkg::div_raw_t raw_o
);

  div_pkg::div_state_e state_q;
  div_pkg::div_state_e state_d;
  div_pkg::count_t     count_q;

  logic [127:0]   acc_q;      // remainder in 127:64, dividend/quotient in 63:0
  div_pkg::xlen_t divisor_q;
  logic [64:0]    trial;      // 65-bit trial difference
  logic           accept;
  logic           last_iter;

  // retained job info
  logic           is_rem_q;
  logic           is_word_q;
  logic           quot_neg_q;
  logic           rem_neg_q;
  logic           special_q;
  div_pkg::xlen_t special_val_q;

  assign accept    = req_valid_i & req_ready_o;
  assign last_iter = (count_q == div_pkg::count_t'(1));
  assign trial     = acc_q[127:63] - {1'b0, divisor_q};

  // ====================
  // control
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      div_pkg::ST_IDLE: if (accept) state_d = job_i.special ? div_pkg::ST_DONE : div_pkg::ST_RUN;
      div_pkg::ST_RUN:  if (last_iter) state_d = div_pkg::ST_DONE;
      div_pkg::ST_DONE: if (res_ready_i) state_d = div_pkg::ST_IDLE;
      default:          state_d = div_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= div_pkg::ST_IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        count_q <= job_i.is_word ? div_pkg::count_t'(32) : div_pkg::count_t'(64);
      end else if (state_q == div_pkg::ST_RUN) begin
        count_q <= count_q - div_pkg::count_t'(1);
      end
    end
  end

  // ====================
  // datapath
  // ====================
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q         <= {64'b0, job_i.dividend};
      divisor_q     <= job_i.divisor;
      is_rem_q      <= job_i.is_rem;
      is_word_q     <= job_i.is_word;
      quot_neg_q    <= job_i.quot_neg;
      rem_neg_q     <= job_i.rem_neg;
      special_q     <= job_i.special;
      special_val_q <= job_i.special_val;
    end else if (state_q == div_pkg::ST_RUN) begin
      if (trial[64]) begin
        acc_q <= {acc_q[126:0], 1'b0};  // negative, restore
      end else begin
        acc_q <= {trial[63:0], acc_q[62:0], 1'b1};
      end
    end
  end

  assign req_ready_o = (state_q == div_pkg::ST_IDLE);
  assign res_valid_o = (state_q == div_pkg::ST_DONE);

  always_comb begin
    raw_o.quotient    = acc_q[63:0];
    raw_o.remainder   = acc_q[127:64];
    raw_o.is_rem      = is_rem_q;
    raw_o.is_word     = is_word_q;
    raw_o.quot_neg    = quot_neg_q;
    raw_o.rem_neg     = rem_neg_q;
    raw_o.special     = special_q;
    raw_o.special_val = special_val_q;
  end

endmodule

//--- div_decode.sv
// combinational request decode; special results are already in final architectural form
`timescale 1ns/100ps

module div_decode (
  input  div_pkg::div_req_t req_i,
  output div_pkg::div_job_t job_o
);

  logic is_signed;
  logic is_word;
  logic is_rem;

  div_pkg::half_t a_lo;
  div_pkg::half_t b_lo;
  div_pkg::xlen_t a_sext;
  div_pkg::xlen_t b_sext;
  div_pkg::xlen_t a_ext;    // operand as the divider sees it
  div_pkg::xlen_t b_ext;
  div_pkg::xlen_t a_final;  // isa view of rs1, sign-extended for word ops
  div_pkg::xlen_t a_mag;
  div_pkg::xlen_t b_mag;
  div_pkg::xlen_t min_val;

  logic a_neg;
  logic b_neg;
  logic div_zero;
  logic overflow;

  // ====================
  // op classification
  // ====================
  assign is_signed = req_i.op inside {div_pkg::OP_DIV, div_pkg::OP_REM,
                                      div_pkg::OP_DIVW, div_pkg::OP_REMW};
  assign is_word   = req_i.op inside {div_pkg::OP_DIVW, div_pkg::OP_DIVUW,
                                      div_pkg::OP_REMW, div_pkg::OP_REMUW};
  assign is_rem    = req_i.op inside {div_pkg::OP_REM, div_pkg::OP_REMU,
                                      div_pkg::OP_REMW, div_pkg::OP_REMUW};

  // ====================
  // operand preparation
  // ====================
  assign a_lo   = req_i.dividend[31:0];  // upper bits ignored for word ops
  assign b_lo   = req_i.divisor[31:0];
  assign a_sext = {{32{a_lo[31]}}, a_lo};
  assign b_sext = {{32{b_lo[31]}}, b_lo};

  always_comb begin
    if (is_word) begin
      a_ext = is_signed ? a_sext : {32'b0, a_lo};
      b_ext = is_signed ? b_sext : {32'b0, b_lo};
    end else begin
      a_ext = req_i.dividend;
      b_ext = req_i.divisor;
    end
  end

  assign a_final = is_word ? a_sext : req_i.dividend;

  assign a_neg = is_signed & a_ext[63];
  assign b_neg = is_signed & b_ext[63];
  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;  // word magnitudes fit in 32 bits

  // ====================
  // special cases
  // ====================
  // divw/remw only look at the low divisor half
  assign div_zero = is_word ? (b_lo == '0) : (req_i.divisor == '0);

  assign min_val  = is_word ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
  assign overflow = is_signed & (a_ext == min_val) & (b_ext == '1);

  // ====================
  // job assembly
  // ====================
  always_comb begin
    job_o.is_rem   = is_rem;
    job_o.is_word  = is_word;
    job_o.quot_neg = a_neg ^ b_neg;
    job_o.rem_neg  = a_neg;  // remainder follows the dividend sign
    job_o.special  = div_zero | overflow;

    // word dividend goes in the top half so 32 steps finish aligned
    if (is_word) begin
      job_o.dividend = {a_mag[31:0], 32'b0};
      job_o.divisor  = {32'b0, b_mag[31:0]};
    end else begin
      job_o.dividend = a_mag;
      job_o.divisor  = b_mag;
    end

    if (div_zero) begin
      job_o.special_val = is_rem ? a_final : '1;  // q = all ones, r = rs1
    end else if (overflow) begin
      job_o.special_val = is_rem ? '0 : a_final;  // q = rs1, r = 0
    end else begin
      job_o.special_val = '0;
    end
  end

endmodule

//--- div_pkg.sv
// shared types of the rv64m divider; widths are fixed at 64/32 by the isa and cannot be changed
package div_pkg;

  // ====================
  // width types
  // ====================
  typedef logic [63:0] xlen_t;   // full operand / result word
  typedef logic [31:0] half_t;   // word-op operand slice
  typedef logic [6:0]  count_t;  // iteration count, holds 64

  // ====================
  // operation and state encodings
  // ====================
  typedef enum logic [2:0] {
    OP_DIV   = 3'd0,
    OP_DIVU  = 3'd1,
    OP_REM   = 3'd2,
    OP_REMU  = 3'd3,
    OP_DIVW  = 3'd4,
    OP_DIVUW = 3'd5,
    OP_REMW  = 3'd6,
    OP_REMUW = 3'd7
  } div_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } div_state_e;

  // ====================
  // stage payloads
  // ====================
  typedef struct packed {
    div_op_e op;
    xlen_t   dividend;  // rs1
    xlen_t   divisor;   // rs2
  } div_req_t;

  // word jobs carry the dividend magnitude in bits 63:32
  typedef struct packed {
    logic  is_rem;
    logic  is_word;
    xlen_t dividend;     // magnitude
    xlen_t divisor;      // magnitude
    logic  quot_neg;
    logic  rem_neg;
    logic  special;      // div by zero or signed overflow
    xlen_t special_val;  // final architectural result
  } div_job_t;

  typedef struct packed {
    xlen_t quotient;   // unsigned
    xlen_t remainder;  // unsigned
    logic  is_rem;
    logic  is_word;
    logic  quot_neg;
    logic  rem_neg;
    logic  special;
    xlen_t special_val;
  } div_raw_t;

endpackage
